// ==== files.f ====
+incdir+common
common/cart_pkg.sv
common/rom_mem_if.sv
loader/header_scanner.sv
loader/region_select.sv
loader/rom_loader.sv
source/rom_arbiter.sv
source/cart_front.sv
verification/cart_front_properties.sv
verification/cart_front_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cart_front testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
	-f files.f --top-module cart_front_tb -o cart_front_sim &&
./obj_dir/cart_front_sim | tee /dev/stderr | grep -x "No errors" > /dev/null &&
echo "Simulation passed" ||
{
	echo "Simulation failed"
	exit 1
}

// ==== verification/cart_front_tb.sv ====
// Cartridge front end testbench
`timescale 1ns/1ps

`include "cart_config.svh"

module cart_front_tb;
	import cart_pkg::*;

	localparam int N_WORDS  = 300;
	localparam int N_IMAGES = 4;
	// Download, console traffic and readback, up to 32 cycles per word
	localparam int CYCLE_LIMIT = N_IMAGES * N_WORDS * 8 * 4;

	logic                clk_sys = 1'b0;
	logic                RESET;
	logic                cart_download;
	logic                ioctl_wr;
	logic [`HOST_AW-1:0] ioctl_addr;
	rom_word_t           ioctl_data;
	logic                auto_region;
	region_prio_t        region_prio;
	rom_addr_t           rom_addr;
	logic                rom_req;
	logic                mem_ack = 1'b0;
	rom_word_t           mem_rdata = '0;
	logic                ioctl_wait;
	logic [`HOST_AW-1:0] rom_size;
	rom_word_t           rom_data;
	logic                rom_ack;
	region_t             region_req;
	logic                region_set;
	quirk_t              quirks;
	rom_addr_t           mem_addr;
	rom_word_t           mem_wdata;
	logic                mem_we;
	logic                mem_req;

	rom_word_t  image [N_WORDS];
	rom_word_t  mem_model [1024];   // Covers the 300 word image
	int         errors = 0;
	int         cycles = 0;
	int         set_count = 0;
	int         words_done;
	int         mem_delay = 0;
	int         mem_lat;
	logic       mem_busy = 1'b0;
	logic       loading;
	region_t    exp_region;
	quirk_t     exp_quirks;
	hdr_flags_t exp_flags;

	cart_front u_cart_front (.*);

	always #4 clk_sys = ~clk_sys;

	function automatic rom_word_t swap_bytes(rom_word_t w);
		return {w[7:0], w[15:8]};
	endfunction

	// First flagged region in the priority order, else the order's head
	function automatic region_t expected_region(hdr_flags_t f, region_prio_t p);
		case (p)
			PRIO_US_EU_JP: return f.u ? REGION_US : f.e ? REGION_EU : f.j ? REGION_JP : REGION_US;
			PRIO_EU_US_JP: return f.e ? REGION_EU : f.u ? REGION_US : f.j ? REGION_JP : REGION_EU;
			PRIO_US_JP_EU: return f.u ? REGION_US : f.j ? REGION_JP : f.e ? REGION_EU : REGION_US;
			default:       return f.j ? REGION_JP : f.u ? REGION_US : f.e ? REGION_EU : REGION_JP;
		endcase
	endfunction

	task automatic value_error(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		errors++;
		$display("** Error: %s = %h, expected %h", name, got, exp);
	endtask

	task automatic note_failure(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	// Host byte order, even byte in the low half
	function automatic void set_byte(input int addr, input logic [7:0] b);
		if (addr % 2 == 1) image[addr / 2][15:8] = b;
		else image[addr / 2][7:0] = b;
	endfunction

	////////////////////////////////////////////////////
	// Memory model, 1 to 4 cycles per request

	always @(posedge clk_sys) begin
		if (RESET) begin
			mem_busy <= 1'b0;
			mem_ack  <= 1'b0;
		end else if (mem_req != mem_ack) begin
			mem_lat = mem_busy ? mem_delay : int'($urandom % 4);
			if (mem_lat == 0) begin
				mem_busy <= 1'b0;
				mem_ack  <= mem_req;
				if (mem_we) mem_model[mem_addr[9:0]] <= mem_wdata;
				else mem_rdata <= mem_model[mem_addr[9:0]];
			end else begin
				mem_busy  <= 1'b1;
				mem_delay <= mem_lat - 1;
			end
		end
	end

	// Host, region strobe and run length monitor
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		assert (!(ioctl_wr && ioctl_wait))
			else note_failure("Host wrote while ioctl_wait was high");
		if (region_set) begin
			set_count <= set_count + 1;
			assert (region_req == exp_region)
				else value_error("region_req", region_req, exp_region);
		end
		if (cycles == CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles with %0d errors counted", cycles, errors);
			$display("Errors found");
			$finish;
		end
	end

	////////////////////////////////////////////////////
	// Stimulus tasks

	task automatic build_image(input int k);
		logic [63:0] sn;
		logic [23:0] rg;
		int i;
		for (i = 0; i < N_WORDS; i++) image[i] = rom_word_t'($urandom);
		exp_quirks = '0;
		case (k)
			0: begin
				sn = "T-081276";
				rg = "J E";            // J and E
				exp_flags = 3'b101;
				exp_quirks.sram = 1'b1;
			end
			1: begin
				sn = "MK-1215 ";
				rg = "4J ";            // Digit 4 gives U, then J
				exp_flags = 3'b110;
				exp_quirks.eeprom = 1'b1;
			end
			2: begin
				sn = "T-35036 ";
				rg = "9  ";            // E and J
				exp_flags = 3'b101;
				exp_quirks.fmbusy = 1'b1;
			end
			default: begin
				sn = "T-999999";       // Not in the table
				rg = "0  ";
				exp_flags = 3'b000;
			end
		endcase
		for (i = 0; i < 8; i++) set_byte('h183 + i, sn[63 - 8 * i -: 8]);
		for (i = 0; i < 3; i++) set_byte(`HDR_REGION_A + i, rg[23 - 8 * i -: 8]);
		exp_region = expected_region(exp_flags, region_prio_t'(k));
	endtask

	task automatic host_write(input int idx);
		@(posedge clk_sys);
		ioctl_wr   <= 1'b1;
		ioctl_addr <= `HOST_AW'(idx * 2);
		ioctl_data <= image[idx];
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		@(posedge clk_sys);
		assert (ioctl_wait) else note_failure("ioctl_wait did not rise after a host write");
		while (ioctl_wait) @(posedge clk_sys);
		// Word must be stored before the host is released
		assert (mem_model[idx] == swap_bytes(image[idx]))
			else value_error("mem_model", mem_model[idx], swap_bytes(image[idx]));
		words_done = idx + 1;
	endtask

	task automatic download(input int k);
		int i;
		@(posedge clk_sys);
		cart_download <= 1'b1;
		region_prio   <= region_prio_t'(k);
		for (i = 0; i < N_WORDS; i++) begin
			if (i == `HDR_ID_DONE / 2)
				assert (quirks == '0) else value_error("quirks", quirks, 0);
			host_write(i);
			if (i == `HDR_ID_DONE / 2)
				assert (quirks == exp_quirks) else value_error("quirks", quirks, exp_quirks);
		end
		@(posedge clk_sys);
		cart_download <= 1'b0;
		repeat (2) @(posedge clk_sys);
		assert (rom_size == (N_WORDS - 1) * 2)
			else value_error("rom_size", rom_size, (N_WORDS - 1) * 2);
	endtask

	task automatic check_read(input int idx);
		@(posedge clk_sys);
		rom_addr <= rom_addr_t'(idx);
		rom_req  <= ~rom_req;
		@(posedge clk_sys);
		while (rom_ack != rom_req) @(posedge clk_sys);
		assert (rom_data == swap_bytes(image[idx]))
			else value_error("rom_data", rom_data, swap_bytes(image[idx]));
	endtask

	// Console reads of words already stored, while the loader runs
	task automatic console_traffic();
		while (loading) begin
			if (words_done > 0) check_read(int'($urandom % words_done));
			else @(posedge clk_sys);
		end
	endtask

	initial begin
		int k;
		int i;
		void'($urandom(80977));
		RESET         = 1'b1;
		cart_download = 1'b0;
		ioctl_wr      = 1'b0;
		ioctl_addr    = '0;
		ioctl_data    = '0;
		auto_region   = 1'b1;
		region_prio   = PRIO_US_EU_JP;
		rom_addr      = '0;
		rom_req       = 1'b0;
		repeat (4) @(posedge clk_sys);
		RESET <= 1'b0;
		for (k = 0; k < N_IMAGES; k++) begin
			build_image(k);
			words_done = 0;
			loading    = 1'b1;
			fork
				begin
					download(k);
					loading = 1'b0;
				end
				console_traffic();
			join
			assert (set_count == k + 1)
				else note_failure("region_set did not pulse once per image");
			for (i = 0; i < N_WORDS; i++) check_read(i);   // Full readback
		end
		errors += u_cart_front.u_cart_front_properties.fail_count;
		$display("Cycles: %0d, error count: %0d", cycles, errors);
		if (errors == 0) $display("No errors");
		else $display("Errors found");
		$finish;
	end

endmodule

// ==== verification/cart_front_properties.sv ====
// Front end handshake properties
`timescale 1ns/1ps

module cart_front_properties (
	input logic clk_sys,
	input logic RESET,
	input logic mem_req,
	input logic mem_ack,
	input logic region_set,
	input logic ioctl_wait
);

	int fail_count = 0;

	// No new memory request while one is outstanding
	property p_mem_req_hold;
		@(posedge clk_sys) disable iff (RESET)
		(mem_req != mem_ack) |=> $stable(mem_req);
	endproperty

	property p_region_set_pulse;
		@(posedge clk_sys) disable iff (RESET)
		region_set |=> !region_set;
	endproperty

	// Host is free straight out of reset
	property p_wait_after_reset;
		@(posedge clk_sys)
		RESET |=> !ioctl_wait;
	endproperty

	a_mem_req_hold: assert property (p_mem_req_hold)
		else begin
			$error("mem_req toggled while a memory request was outstanding");
			fail_count++;
		end

	a_region_set_pulse: assert property (p_region_set_pulse)
		else begin
			$error("region_set stayed high for two cycles");
			fail_count++;
		end

	a_wait_after_reset: assert property (p_wait_after_reset)
		else begin
			$error("ioctl_wait high in the cycle after reset");
			fail_count++;
		end

endmodule

bind cart_front cart_front_properties u_cart_front_properties (
	.clk_sys    (clk_sys),
	.RESET      (RESET),
	.mem_req    (mem_req),
	.mem_ack    (mem_ack),
	.region_set (region_set),
	.ioctl_wait (ioctl_wait)
);

// ==== source/cart_front.sv ====
// Cartridge loading front end
`timescale 1ns/1ps

`include "cart_config.svh"

module cart_front (
	input  logic                   clk_sys,
	input  logic                   RESET,
	input  logic                   cart_download,
	input  logic                   ioctl_wr,
	input  logic [`HOST_AW-1:0]    ioctl_addr,
	input  cart_pkg::rom_word_t    ioctl_data,
	input  logic                   auto_region,
	input  cart_pkg::region_prio_t region_prio,
	input  cart_pkg::rom_addr_t    rom_addr,
	input  logic                   rom_req,
	input  logic                   mem_ack,
	input  cart_pkg::rom_word_t    mem_rdata,
	output logic                   ioctl_wait,
	output logic [`HOST_AW-1:0]    rom_size,
	output cart_pkg::rom_word_t    rom_data,
	output logic                   rom_ack,
	output cart_pkg::region_t      region_req,
	output logic                   region_set,
	output cart_pkg::quirk_t       quirks,
	output cart_pkg::rom_addr_t    mem_addr,
	output cart_pkg::rom_word_t    mem_wdata,
	output logic                   mem_we,
	output logic                   mem_req
);

	cart_pkg::hdr_flags_t hdr_flags;
	logic                 hdr_ready;

	rom_mem_if ldr_bus ();
	rom_mem_if con_bus ();
	rom_mem_if mem_bus ();

	// Console read port, never writes
	assign con_bus.addr  = rom_addr;
	assign con_bus.wdata = '0;
	assign con_bus.we    = 1'b0;
	assign con_bus.req   = rom_req;
	assign rom_data      = con_bus.rdata;
	assign rom_ack       = con_bus.ack;

	// External memory
	assign mem_addr      = mem_bus.addr;
	assign mem_wdata     = mem_bus.wdata;
	assign mem_we        = mem_bus.we;
	assign mem_req       = mem_bus.req;
	assign mem_bus.ack   = mem_ack;
	assign mem_bus.rdata = mem_rdata;

	header_scanner u_header_scanner (.*);

	region_select u_region_select (.*);

	rom_loader u_rom_loader (.*, .mem(ldr_bus.requester));

	rom_arbiter u_rom_arbiter (
		.clk_sys (clk_sys),
		.RESET   (RESET),
		.ldr     (ldr_bus.server),
		.con     (con_bus.server),
		.mem     (mem_bus.requester)
	);

endmodule

// ==== source/rom_arbiter.sv ====
// ROM memory arbiter
`timescale 1ns/1ps

module rom_arbiter (
	input  logic         clk_sys,
	input  logic         RESET,
	rom_mem_if.server    ldr,
	rom_mem_if.server    con,
	rom_mem_if.requester mem
);

	logic busy;       // One request in flight to memory
	logic grant_con;  // Current owner, console when set
	logic ldr_pend;
	logic con_pend;
	logic mem_done;
	logic start_ldr;
	logic start_con;

	assign ldr_pend  = ldr.req != ldr.ack;
	assign con_pend  = con.req != con.ack;
	assign mem_done  = busy && (mem.req == mem.ack);
	assign start_ldr = !busy && ldr_pend;              // Loader has priority
	assign start_con = !busy && !ldr_pend && con_pend;

	////////////////////////////////////////////////////
	// Grant and handshake control

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			busy      <= 1'b0;
			grant_con <= 1'b0;
			mem.req   <= 1'b0;
			ldr.ack   <= 1'b0;
			con.ack   <= 1'b0;
		end else if (start_ldr || start_con) begin
			busy      <= 1'b1;
			grant_con <= start_con;
			mem.req   <= ~mem.req;
		end else if (mem_done) begin
			busy <= 1'b0;
			if (grant_con) con.ack <= con.req;
			else ldr.ack <= ldr.req;
		end
	end

	////////////////////////////////////////////////////
	// Request copy and read return

	always_ff @(posedge clk_sys) begin
		if (start_ldr) begin
			mem.addr  <= ldr.addr;
			mem.wdata <= ldr.wdata;
			mem.we    <= ldr.we;
		end else if (start_con) begin
			mem.addr  <= con.addr;
			mem.wdata <= con.wdata;
			mem.we    <= con.we;
		end
		if (mem_done) begin
			if (grant_con) con.rdata <= mem.rdata;
			else ldr.rdata <= mem.rdata;
		end
	end

endmodule

// ==== loader/rom_loader.sv ====
// Host download to ROM writer
`timescale 1ns/1ps

`include "cart_config.svh"

module rom_loader (
	input  logic                clk_sys,
	input  logic                RESET,
	input  logic                cart_download,
	input  logic                ioctl_wr,
	input  logic [`HOST_AW-1:0] ioctl_addr,
	input  cart_pkg::rom_word_t ioctl_data,
	output logic                ioctl_wait,
	output logic [`HOST_AW-1:0] rom_size,
	rom_mem_if.requester        mem
);

	logic dl_q;

	assign mem.we = 1'b1; // Loader only ever writes

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_q       <= 1'b0;
			ioctl_wait <= 1'b0;
			mem.req    <= 1'b0;
			rom_size   <= '0;
		end else begin
			dl_q <= cart_download;
			if (dl_q && !cart_download) rom_size <= ioctl_addr; // Last byte address
			if (cart_download && ioctl_wr) begin
				ioctl_wait <= 1'b1; // Hold host until stored
				mem.req    <= ~mem.req;
			end else if (ioctl_wait && mem.req == mem.ack) begin
				ioctl_wait <= 1'b0;
			end
		end
	end

	// Word address and byte-swapped data
	always_ff @(posedge clk_sys) begin
		if (cart_download && ioctl_wr) begin
			mem.addr  <= ioctl_addr[`HOST_AW-1:1];
			mem.wdata <= {ioctl_data[7:0], ioctl_data[15:8]};
		end
	end

endmodule

// ==== loader/region_select.sv ====
// Console region selection
`timescale 1ns/1ps

`include "cart_config.svh"

module region_select (
	input  logic                   clk_sys,
	input  logic                   RESET,
	input  logic                   hdr_ready,
	input  cart_pkg::hdr_flags_t   hdr_flags,
	input  logic                   auto_region,
	input  cart_pkg::region_prio_t region_prio,
	output cart_pkg::region_t      region_req,
	output logic                   region_set
);
	import cart_pkg::*;

	logic ready_q;

	function automatic logic region_seen(hdr_flags_t f, region_t r);
		case (r)
			REGION_JP: return f.j;
			REGION_US: return f.u;
			REGION_EU: return f.e;
			default:   return 1'b0;
		endcase
	endfunction

	// First flagged region in the order, else the order's head
	function automatic region_t pick_region(hdr_flags_t f, region_prio_t p);
		region_t order [3];
		region_t res;
		int i;
		case (p)
			PRIO_US_EU_JP: order = '{REGION_US, REGION_EU, REGION_JP};
			PRIO_EU_US_JP: order = '{REGION_EU, REGION_US, REGION_JP};
			PRIO_US_JP_EU: order = '{REGION_US, REGION_JP, REGION_EU};
			default:       order = '{REGION_JP, REGION_US, REGION_EU};
		endcase
		res = order[0];
		for (i = 2; i >= 0; i--) begin
			if (region_seen(f, order[i])) res = order[i]; // Lowest index wins
		end
		return res;
	endfunction

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			ready_q    <= 1'b0;
			region_req <= region_t'(`DEFAULT_REGION);
			region_set <= 1'b0;
		end else begin
			ready_q    <= hdr_ready;
			region_set <= 1'b0; // Single-cycle strobe
			if (hdr_ready && !ready_q && auto_region) begin
				region_req <= pick_region(hdr_flags, region_prio);
				region_set <= 1'b1;
			end
		end
	end

endmodule

// ==== loader/header_scanner.sv ====
// Cartridge header scanner
`timescale 1ns/1ps

`include "cart_config.svh"

module header_scanner (
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  logic                 cart_download,
	input  logic                 ioctl_wr,
	input  logic [`HOST_AW-1:0]  ioctl_addr,
	input  cart_pkg::rom_word_t  ioctl_data,
	output cart_pkg::hdr_flags_t hdr_flags,
	output logic                 hdr_ready,
	output cart_pkg::quirk_t     quirks
);
	import cart_pkg::*;

	logic       dl_q;
	logic       wr_en;
	logic       dl_rise;
	logic       dl_fall;
	logic [7:0] lo_byte;
	logic [3:0] hex_rgn;
	logic [63:0] cart_id;  // Serial, first character in the top byte
	hdr_flags_t flags_nxt;

	assign wr_en   = cart_download & ioctl_wr;
	assign dl_rise = cart_download & ~dl_q;
	assign dl_fall = ~cart_download & dl_q;
	assign lo_byte = ioctl_data[7:0];
	assign hex_rgn = lo_byte[3:0] - 4'd7; // 'A'..'F' mapped onto 10..15

	function automatic hdr_flags_t mark_letter(hdr_flags_t f, logic [7:0] c);
		if (c == "J") f.j = 1'b1;
		else if (c == "U") f.u = 1'b1;
		else if (c == "E") f.e = 1'b1;
		return f;
	endfunction

	////////////////////////////////////////////////////
	// Region field decode

	always_comb begin
		flags_nxt = hdr_flags;
		if (ioctl_addr == `HDR_REGION_A) begin
			if (lo_byte == "J" || lo_byte == "U" || lo_byte == "E") begin
				flags_nxt = mark_letter(flags_nxt, lo_byte);
			end else if (lo_byte >= "0" && lo_byte <= "9") begin
				flags_nxt.e = lo_byte[3]; // New style bitmask code
				flags_nxt.u = lo_byte[2];
				flags_nxt.j = lo_byte[0];
			end else if (lo_byte >= "A" && lo_byte <= "F") begin
				flags_nxt.e = hex_rgn[3];
				flags_nxt.u = hex_rgn[2];
				flags_nxt.j = hex_rgn[0];
			end
			flags_nxt = mark_letter(flags_nxt, ioctl_data[15:8]);
		end
		if (ioctl_addr == `HDR_REGION_B)
			flags_nxt = mark_letter(flags_nxt, lo_byte);
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_q      <= 1'b0;
			hdr_flags <= '0;
			hdr_ready <= 1'b0;
		end else begin
			dl_q <= cart_download;
			if (dl_rise) hdr_flags <= '0;            // New image
			else if (wr_en) hdr_flags <= flags_nxt;
			if (dl_fall) hdr_ready <= 1'b0;
			else if (wr_en && ioctl_addr == `HDR_END) hdr_ready <= 1'b1;
		end
	end

	////////////////////////////////////////////////////
	// Serial capture and quirk table

	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			case (ioctl_addr)
				`HDR_ID_FIRST:     cart_id[63:56] <= ioctl_data[15:8];
				`HDR_ID_FIRST + 2: cart_id[55:40] <= {ioctl_data[7:0], ioctl_data[15:8]};
				`HDR_ID_FIRST + 4: cart_id[39:24] <= {ioctl_data[7:0], ioctl_data[15:8]};
				`HDR_ID_FIRST + 6: cart_id[23:8]  <= {ioctl_data[7:0], ioctl_data[15:8]};
				`HDR_ID_LAST:      cart_id[7:0]   <= ioctl_data[7:0];
				default:           cart_id        <= cart_id;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET || dl_rise) begin
			quirks <= '0;
		end else if (wr_en && ioctl_addr == `HDR_ID_DONE) begin
			if (cart_id == "T-081276") quirks.sram <= 1'b1;        // Battery save
			else if (cart_id == "MK-1215 ") quirks.eeprom <= 1'b1; // Serial EEPROM save
			else if (cart_id == "T-113016") quirks.noram <= 1'b1;  // Fails on RAM present
			else if (cart_id == "T-89016 ") quirks.fifo <= 1'b1;
			else if (cart_id == "MK-1229 ") quirks.svp <= 1'b1;
			else if (cart_id == "T-35036 ") quirks.fmbusy <= 1'b1;
		end
	end

endmodule

// ==== common/rom_mem_if.sv ====
// ROM memory port
`timescale 1ns/1ps

interface rom_mem_if;
	import cart_pkg::*;

	rom_addr_t addr;
	rom_word_t wdata;
	rom_word_t rdata;
	logic      we;
	logic      req;   // Toggles to start a request
	logic      ack;   // Equals req when done

	modport requester (
		output addr, wdata, we, req,
		input  rdata, ack
	);

	modport server (
		input  addr, wdata, we, req,
		output rdata, ack
	);

endinterface

// ==== common/cart_pkg.sv ====
// Cartridge front end types

`include "cart_config.svh"

package cart_pkg;

	// Console region codes
	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_t;

	// Region priority orders, first entry wins
	typedef enum logic [1:0] {
		PRIO_US_EU_JP = 2'd0,
		PRIO_EU_US_JP = 2'd1,
		PRIO_US_JP_EU = 2'd2,
		PRIO_JP_US_EU = 2'd3
	} region_prio_t;

	typedef struct packed {
		logic j; // Japan seen in header
		logic u; // USA
		logic e; // Europe
	} hdr_flags_t;

	// Per-game quirk flags
	typedef struct packed {
		logic sram;
		logic eeprom;
		logic noram;
		logic fifo;
		logic svp;
		logic fmbusy;
	} quirk_t;

	typedef logic [15:0]         rom_word_t;
	typedef logic [`ROM_AW-1:0]  rom_addr_t; // Word address

endpackage

// ==== common/cart_config.svh ====
// Cartridge loader configuration
`ifndef CART_CONFIG_SVH
`define CART_CONFIG_SVH

// ROM word address width
`define ROM_AW 24

// Host byte address width
`define HOST_AW 25

// Cartridge serial field, byte addresses
`define HDR_ID_FIRST 'h182
`define HDR_ID_LAST  'h18A
`define HDR_ID_DONE  'h18C // Serial complete, table lookup here

// Region letters
`define HDR_REGION_A 'h1F0
`define HDR_REGION_B 'h1F2

// Header fully received
`define HDR_END 'h200

// Region after reset, US
`define DEFAULT_REGION 1

`endif
